//--- verilog/nn_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, lengths and types of the pixel path
// imported by every stage and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package nn_pkg;

    // stream geometry
    localparam int DATA_WIDTH = 8;      // bits per pixel
    localparam int POOL_LEN   = 7;      // pixels merged into one max
    localparam int UP_LEN     = 7;      // copies per pooled pixel
    localparam int CNT_WIDTH  = 3;      // fits 0..6 for both counters

    typedef logic [DATA_WIDTH-1:0] pixel_t;

    // one stream beat, strobe plus framing pulses
    typedef struct packed {
        logic   valid;                  // beat carries a pixel
        pixel_t pixel;                  // pixel value
        logic   sop;                    // first pixel of a string
        logic   eop;                    // last pixel of a string
        logic   sof;                    // first pixel of a frame
        logic   eof;                    // last pixel of a frame
    } beat_t;

    // up-sampler FSM
    typedef enum logic {
        UP_IDLE   = 1'b0,               // waiting for a pooled beat
        UP_REPEAT = 1'b1                // emitting copies
    } up_state_e;

endpackage

`default_nettype wire

//--- verilog/max_pool_7.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// max pooling over groups of seven valid pixels of a string
// emits one beat per group, a cycle after its seventh pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module max_pool_7
    import nn_pkg::*;
(
    input  wire logic  clk_i,           // pixel clock
    input  wire logic  arst_n_i,        // async reset, active low
    input  wire beat_t beat_i,          // incoming pixel beat
    output beat_t      beat_o           // pooled beat, one-cycle pulse
);

    logic [CNT_WIDTH-1:0] grp_cnt;      // position inside current group
    pixel_t               max_q;        // running maximum of the group
    logic                 sop_q;        // sop seen earlier in group
    logic                 sof_q;        // sof seen earlier in group

    logic                 grp_first;    // pixel opens a group
    logic                 grp_last;     // pixel closes a group
    pixel_t               max_nxt;      // max including this pixel
    logic                 sop_nxt;      // merged sop including this pixel
    logic                 sof_nxt;      // merged sof including this pixel

    logic                 out_valid;    // result strobe
    pixel_t               out_pixel;    // result maximum
    logic                 out_sop;
    logic                 out_eop;
    logic                 out_sof;
    logic                 out_eof;

    always_comb begin
        grp_first = (grp_cnt == '0);
        grp_last  = (grp_cnt == CNT_WIDTH'(POOL_LEN - 1));
        // first pixel loads, later pixels compare
        if (grp_first || (beat_i.pixel > max_q)) begin
            max_nxt = beat_i.pixel;
        end else begin
            max_nxt = max_q;
        end
        sop_nxt = beat_i.sop | (sop_q & ~grp_first);  // stale flags dropped on group start
        sof_nxt = beat_i.sof | (sof_q & ~grp_first);
    end

    // group counter, start flags and result pulse
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grp_cnt   <= '0;
            sop_q     <= 1'b0;
            sof_q     <= 1'b0;
            out_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
        end else begin
            out_valid <= 1'b0;              // pulse by default
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
            if (beat_i.valid) begin
                sop_q <= sop_nxt;
                sof_q <= sof_nxt;
                if (grp_last) begin
                    grp_cnt   <= '0;        // next pixel starts fresh group
                    out_valid <= 1'b1;
                    out_sop   <= sop_nxt;
                    out_sof   <= sof_nxt;
                    out_eop   <= beat_i.eop;  // end flags from seventh pixel
                    out_eof   <= beat_i.eof;
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end
        end
    end

    // maximum and result pixel
    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            max_q <= max_nxt;
            if (grp_last) begin
                out_pixel <= max_nxt;
            end
        end
    end

    assign beat_o = '{
        valid: out_valid,
        pixel: out_pixel,
        sop:   out_sop,
        eop:   out_eop,
        sof:   out_sof,
        eof:   out_eof
    };

    // string and frame ends must close a group
    a_end_on_last: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (beat_i.valid && (beat_i.eop || beat_i.eof)) |-> grp_last
    ) else $error("max_pool_7: eop/eof inside a group");

    // a string starts on a group boundary
    a_sop_on_first: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (beat_i.valid && beat_i.sop) |-> grp_first
    ) else $error("max_pool_7: sop inside a group");

endmodule

`default_nettype wire

//--- verilog/up_sampling_7.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// repeats each pooled beat seven times on consecutive cycles
// start flags on copy one, end flags on copy seven
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module up_sampling_7
    import nn_pkg::*;
(
    input  wire logic  clk_i,           // pixel clock
    input  wire logic  arst_n_i,        // async reset, active low
    input  wire beat_t beat_i,          // pooled beat from max_pool_7
    output beat_t      beat_o           // repeated output beats
);

    up_state_e            state_q;      // FSM state
    logic [CNT_WIDTH-1:0] copy_cnt;     // copy index, 0 is copy one
    pixel_t               hold_pixel;   // latched pooled pixel
    logic                 hold_sop;     // latched framing of pooled beat
    logic                 hold_eop;
    logic                 hold_sof;
    logic                 hold_eof;

    logic                 repeating;    // emitting a copy this cycle
    logic                 copy_first;   // copy one
    logic                 copy_last;    // copy seven
    logic                 load;         // latch a new pooled beat

    always_comb begin
        repeating  = (state_q == UP_REPEAT);
        copy_first = (copy_cnt == '0);
        copy_last  = (copy_cnt == CNT_WIDTH'(UP_LEN - 1));
        // accepted when idle, or back to back on the last copy
        load       = beat_i.valid && (!repeating || copy_last);
    end

    // FSM and copy counter
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= UP_IDLE;
            copy_cnt <= '0;
            hold_sop <= 1'b0;
            hold_eop <= 1'b0;
            hold_sof <= 1'b0;
            hold_eof <= 1'b0;
        end else begin
            if (load) begin
                state_q  <= UP_REPEAT;
                copy_cnt <= '0;
                hold_sop <= beat_i.sop;
                hold_eop <= beat_i.eop;
                hold_sof <= beat_i.sof;
                hold_eof <= beat_i.eof;
            end else begin
                case (state_q)
                    UP_IDLE: begin
                        copy_cnt <= '0;
                    end
                    UP_REPEAT: begin
                        if (copy_last) begin
                            state_q  <= UP_IDLE;    // run finished, nothing queued
                            copy_cnt <= '0;
                        end else begin
                            copy_cnt <= copy_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state_q <= UP_IDLE;
                    end
                endcase
            end
        end
    end

    // payload, only meaningful while repeating
    always_ff @(posedge clk_i) begin
        if (load) begin
            hold_pixel <= beat_i.pixel;
        end
    end

    // output copies straight from the held beat
    assign beat_o = '{
        valid: repeating,
        pixel: hold_pixel,
        sop:   repeating & copy_first & hold_sop,
        eop:   repeating & copy_last  & hold_eop,
        sof:   repeating & copy_first & hold_sof,
        eof:   repeating & copy_last  & hold_eof
    };

    // pooling spacing keeps new beats off the middle of a run
    a_no_overlap: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (beat_i.valid && repeating) |-> copy_last
    ) else $error("up_sampling_7: pooled beat arrived during a repeat");

endmodule

`default_nettype wire

//--- verilog/nn.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel path top, max pooling followed by up-sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module nn
    import nn_pkg::*;
(
    input  wire logic   clk_i,          // single clock for all stages
    input  wire logic   arst_n_i,       // async reset, active low

    input  wire pixel_t data_i,         // input pixel
    input  wire logic   data_valid_i,   // input strobe
    input  wire logic   sop_i,          // string start
    input  wire logic   eop_i,          // string end
    input  wire logic   sof_i,          // frame start
    input  wire logic   eof_i,          // frame end

    output pixel_t      data_o,         // output pixel
    output logic        data_valid_o,   // output strobe
    output logic        sop_o,
    output logic        eop_o,
    output logic        sof_o,
    output logic        eof_o
);

    beat_t beat_in;                     // packed input beat
    beat_t pooled;                      // max_pool_7 -> up_sampling_7
    beat_t beat_out;                    // up-sampler result

    assign beat_in = '{
        valid: data_valid_i,
        pixel: data_i,
        sop:   sop_i,
        eop:   eop_i,
        sof:   sof_i,
        eof:   eof_i
    };

    max_pool_7 max_pool_7_inst (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .beat_i   ( beat_in  ),
        .beat_o   ( pooled   )
    );

    up_sampling_7 up_sampling_7_inst (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .beat_i   ( pooled   ),
        .beat_o   ( beat_out )
    );

    assign data_o       = beat_out.pixel;
    assign data_valid_o = beat_out.valid;
    assign sop_o        = beat_out.sop;
    assign eop_o        = beat_out.eop;
    assign sof_o        = beat_out.sof;
    assign eof_o        = beat_out.eof;

endmodule

`default_nettype wire

//--- verification/tb_nn.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// replays pixel groups from the cases file into the pooling path
// and checks every output copy against beats expected from its rows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_nn
    import nn_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 4;
    localparam int DRAIN_LIMIT = 200;          // cycles for a test to empty its queue
    localparam int SETTLE      = UP_LEN + 3;   // idle cycles that catch stray beats
    localparam int QUIET       = 10;           // cycles watched after a mid-stream reset
    localparam int NUM_TESTS   = 5;

    logic   clk_i;
    logic   arst_n_i;
    pixel_t data_i;
    logic   data_valid_i;
    logic   sop_i;
    logic   eop_i;
    logic   sof_i;
    logic   eof_i;
    pixel_t data_o;
    logic   data_valid_o;
    logic   sop_o;
    logic   eop_o;
    logic   sof_o;
    logic   eof_o;

    beat_t  exp_q[$];                          // copies still owed by the DUT
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     total_checks;
    int     tests_run;
    int     tests_failed;
    int     copies_seen;                       // popped copies, position modulo UP_LEN
    logic   prev_valid;                        // output strobe one cycle earlier

    nn dut_i (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .data_i       ( data_i       ),
        .data_valid_i ( data_valid_i ),
        .sop_i        ( sop_i        ),
        .eop_i        ( eop_i        ),
        .sof_i        ( sof_i        ),
        .eof_i        ( eof_i        ),
        .data_o       ( data_o       ),
        .data_valid_o ( data_valid_o ),
        .sop_o        ( sop_o        ),
        .eop_o        ( eop_o        ),
        .sof_o        ( sof_o        ),
        .eof_o        ( eof_o        )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [$bits(beat_t)-1:0] expected,
                         input logic [$bits(beat_t)-1:0] actual);
        total_checks++;
        if (actual !== expected) begin
            $display("Error: test %s expected %h actual %h", name, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    function automatic string name_of(input int id);
        case (id)
            1:       return "single_group";
            2:       return "max_position";
            3:       return "multi_string";
            4:       return "idle_gaps";
            5:       return "reset_mid_stream";
            default: return $sformatf("test_%0d", id);
        endcase
    endfunction

    // one pixel per rising edge
    task automatic drive_pixel(input pixel_t px, input logic sop, input logic eop,
                               input logic sof, input logic eof);
        @(posedge clk_i);
        data_i       <= px;
        data_valid_i <= 1'b1;
        sop_i        <= sop;
        eop_i        <= eop;
        sof_i        <= sof;
        eof_i        <= eof;
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        data_i       <= '0;
        data_valid_i <= 1'b0;
        sop_i        <= 1'b0;
        eop_i        <= 1'b0;
        sof_i        <= 1'b0;
        eof_i        <= 1'b0;
    endtask

    // start flags go on pixel one and end flags on pixel seven
    task automatic drive_group(input pixel_t px [POOL_LEN], input logic gap, input logic sop,
                               input logic eop, input logic sof, input logic eof,
                               input int count);
        for (int i = 0; i < count; i++) begin
            drive_pixel(px[i], sop && (i == 0), eop && (i == POOL_LEN - 1),
                        sof && (i == 0), eof && (i == POOL_LEN - 1));
            if (gap && (i < count - 1)) begin
                drive_idle();                  // one idle cycle between pixels
            end
        end
    endtask

    // seven copies of the group max with framing on the first or last copy
    task automatic push_expected(input pixel_t max_px, input logic sop, input logic eop,
                                 input logic sof, input logic eof);
        beat_t b;
        for (int k = 0; k < UP_LEN; k++) begin
            b.valid = 1'b1;
            b.pixel = max_px;
            b.sop   = sop && (k == 0);
            b.sof   = sof && (k == 0);
            b.eop   = eop && (k == UP_LEN - 1);
            b.eof   = eof && (k == UP_LEN - 1);
            exp_q.push_back(b);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        drive_idle();
        while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s timed out with %0d output beats missing", test_name, exp_q.size());
            test_errors++;
            total_errors++;
            exp_q.delete();
            copies_seen = 0;
        end
        repeat (SETTLE) @(posedge clk_i);
    endtask

    // mid-group reset keeps every output low
    task automatic reset_and_check();
        beat_t quiet;
        @(posedge clk_i);
        arst_n_i     <= 1'b0;
        data_valid_i <= 1'b0;
        sop_i        <= 1'b0;
        eop_i        <= 1'b0;
        sof_i        <= 1'b0;
        eof_i        <= 1'b0;
        for (int n = 0; n < RST_CYCLES + QUIET; n++) begin
            @(negedge clk_i);
            quiet = '{valid: data_valid_o, pixel: '0, sop: sop_o, eop: eop_o,
                      sof: sof_o, eof: eof_o};  // pixel is don't care when idle
            check(test_name, '0, quiet);
            if (n == RST_CYCLES - 1) begin
                @(posedge clk_i);
                arst_n_i <= 1'b1;
            end
        end
    endtask

    task automatic finish_test(input int id);
        drain();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", id, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", id, test_name, test_errors);
            tests_failed++;
        end
    endtask

    // output copies are sampled mid-cycle
    always @(negedge clk_i) begin : monitor
        beat_t actual;
        actual = '{valid: data_valid_o, pixel: data_o, sop: sop_o, eop: eop_o,
                   sof: sof_o, eof: eof_o};
        if (arst_n_i && data_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("test %s: output beat %h arrived with none expected", test_name, actual);
                test_errors++;
                total_errors++;
            end else begin
                // copies two to seven follow their predecessor directly
                if (((copies_seen % UP_LEN) != 0) && !prev_valid) begin
                    $display("test %s: copy %0d of a pixel came after an idle cycle",
                             test_name, (copies_seen % UP_LEN) + 1);
                    test_errors++;
                    total_errors++;
                end
                copies_seen++;
                check(test_name, exp_q.pop_front(), actual);
            end
        end
        prev_valid = arst_n_i && data_valid_o;
    end

    initial begin : main
        int     fd;
        int     fields;
        int     cur_id;
        int     id;
        int     mode;
        int     f_sop;
        int     f_eop;
        int     f_sof;
        int     f_eof;
        int     f_max;
        int     raw [POOL_LEN];
        pixel_t px [POOL_LEN];
        string  line;

        arst_n_i     = 1'b0;
        data_i       = '0;
        data_valid_i = 1'b0;
        sop_i        = 1'b0;
        eop_i        = 1'b0;
        sof_i        = 1'b0;
        eof_i        = 1'b0;
        test_name    = "reset";
        test_errors  = 0;
        total_errors = 0;
        total_checks = 0;
        tests_run    = 0;
        tests_failed = 0;
        copies_seen  = 0;
        prev_valid   = 1'b0;
        cur_id       = 0;
        repeat (RST_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;

        fd = $fopen("verification/nn_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/nn_cases.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%d %d %d %d %d %d %h %h %h %h %h %h %h %h",
                                 id, mode, f_sop, f_eop, f_sof, f_eof, raw[0], raw[1],
                                 raw[2], raw[3], raw[4], raw[5], raw[6], f_max);
                if (fields == 14) begin
                    if (id != cur_id) begin
                        if (cur_id != 0) begin
                            finish_test(cur_id);
                        end
                        cur_id      = id;
                        test_name   = name_of(id);
                        test_errors = 0;
                    end
                    for (int i = 0; i < POOL_LEN; i++) begin
                        px[i] = pixel_t'(raw[i]);
                    end
                    if (mode == 2) begin
                        drive_group(px, 1'b0, f_sop != 0, f_eop != 0, f_sof != 0,
                                    f_eof != 0, 4);       // partial group then reset
                        reset_and_check();
                    end else begin
                        push_expected(pixel_t'(f_max), f_sop != 0, f_eop != 0,
                                      f_sof != 0, f_eof != 0);
                        drive_group(px, mode != 0, f_sop != 0, f_eop != 0, f_sof != 0,
                                    f_eof != 0, POOL_LEN);
                    end
                end else if ((line.len() > 1) && (line.getc(0) != "#")) begin
                    $display("malformed line in cases file: %s", line);
                    total_errors++;
                end
            end
            $fclose(fd);
            if (cur_id != 0) begin
                finish_test(cur_id);
            end
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, total_checks, total_errors);
            if ((tests_failed == 0) && (total_errors == 0) && (tests_run == NUM_TESTS)) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/nn_cases.txt
# test mode sop eop sof eof p0 p1 p2 p3 p4 p5 p6 max   (pixels and max in hex)
# mode 0 back to back, 1 idle cycle between pixels, 2 reset after four pixels
#
# test 1, one group forms a whole frame
1 0 1 1 1 1 12 4a 33 07 29 20 01 4a
#
# test 2, one string, max at first, middle, last and repeated positions
2 0 1 0 1 0 9c 10 22 31 05 7f 00 9c
2 0 0 0 0 0 03 11 20 e5 40 17 0a e5
2 0 0 0 0 0 20 21 22 23 24 25 fe fe
2 0 0 0 0 0 55 80 12 80 33 80 01 80
2 0 0 0 0 0 00 00 00 00 00 00 00 00
2 0 0 1 0 1 ff ff ff ff ff ff ff ff
#
# test 3, three strings of two groups in one frame
3 0 1 0 1 0 01 02 03 04 05 06 07 07
3 0 0 1 0 0 70 60 50 40 30 20 10 70
3 0 1 0 0 0 aa 0b bb 0c cc 0d 0e cc
3 0 0 1 0 0 11 c3 11 11 11 11 11 c3
3 0 1 0 0 0 7e 7f 80 81 7d 7c 7b 81
3 0 0 1 0 1 fd 02 fc 04 fb 06 fa fd
#
# test 4, pixels of test 2 with idle cycles between them
4 1 1 0 1 0 9c 10 22 31 05 7f 00 9c
4 1 0 0 0 0 03 11 20 e5 40 17 0a e5
4 1 0 0 0 0 20 21 22 23 24 25 fe fe
4 1 0 0 0 0 55 80 12 80 33 80 01 80
4 1 0 0 0 0 00 00 00 00 00 00 00 00
4 1 0 1 0 1 ff ff ff ff ff ff ff ff
#
# test 5, partial group cut by reset, then a fresh frame of two strings
5 2 1 0 1 0 f1 f2 f3 f4 f5 f6 f7 00
5 0 1 0 1 0 61 62 63 64 65 66 67 67
5 0 0 1 0 0 08 19 2a 3b 2a 19 08 3b
5 0 1 1 0 1 44 33 22 99 22 33 44 99

//--- nn_pool.f
verilog/nn_pkg.sv
verilog/max_pool_7.sv
verilog/up_sampling_7.sv
verilog/nn.sv
verification/tb_nn.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the pixel path testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_nn
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf "${BUILD_DIR}" "${LOG}"

verilator --binary --timing --assert -Wno-fatal \
    --top-module "${TOP}" \
    -f nn_pool.f \
    -Mdir "${BUILD_DIR}" \
    -o "V${TOP}"
status=$?
if [ ${status} -ne 0 ]; then
    echo "verilator build failed with status ${status}"
    exit 1
fi

"./${BUILD_DIR}/V${TOP}" 2>&1 | tee "${LOG}"
status=${PIPESTATUS[0]}
if [ ${status} -ne 0 ]; then
    echo "simulation exited with status ${status}"
    exit 1
fi

if grep -Fqx "Simulation finished: PASS" "${LOG}"; then
    echo "run passed"
    exit 0
else
    echo "run failed, see ${LOG}"
    exit 1
fi
